// ==== axi2apb.f ====
+incdir+.
axi_pkg.sv
apb_pkg.sv
axi_req_capture.sv
apb_sequencer.sv
axi_resp_unit.sv
axi2apb_top.sv
tb_clock_gen.sv
axi2apb_assert.sv
axi2apb_tb.sv

// ==== Bender.yml ====
package:
  name: axi2apb

sources:
  - include_dirs:
      - .
    files:
      - axi_pkg.sv
      - apb_pkg.sv
      - axi_req_capture.sv
      - apb_sequencer.sv
      - axi_resp_unit.sv
      - axi2apb_top.sv
      - target: test
        files:
          - tb_clock_gen.sv
          - axi2apb_assert.sv
          - axi2apb_tb.sv

// ==== axi2apb_tb.sv ====
`include "axi2apb_consts.svh"

module axi2apb_tb;

  import axi_pkg::*;

  // --------------------------------------------------
  // Stimulus table
  // --------------------------------------------------
  typedef enum logic [1:0]
  {
    OP_RD,
    OP_WR,
    OP_BOTH  // AR and AW+W presented in the same cycle
  } op_e;

  typedef struct
  {
    op_e                         op;
    logic [`AXI2APB_ADDR_W-1:0]  addr;
    axi_size_t                   size;
    axi_id_t                     id;
    logic [`AXI2APB_AXI_DATA_W-1:0] wdata;
    int                          stall;  // Cycles of RREADY/BREADY low
  } row_t;

  typedef struct
  {
    logic      is_write;
    axi_id_t   id;
    axi_data_u data;
    axi_resp_t resp;
    int        stall;
  } resp_t;

  localparam int N_ROWS = 12;

  row_t rows [N_ROWS] = '{
    '{OP_WR,   32'h0000_0100, 3'd3, 16'h0011, 64'h1122_3344_5566_7788, 0},
    '{OP_RD,   32'h0000_0100, 3'd3, 16'h0012, 64'h0, 0},
    '{OP_WR,   32'h0000_0204, 3'd2, 16'h0021, 64'hcafe_f00d_0bad_beef, 0},
    '{OP_RD,   32'h0000_0204, 3'd2, 16'h0022, 64'h0, 0},
    '{OP_RD,   32'h0000_0200, 3'd2, 16'h0023, 64'h0, 0},
    '{OP_WR,   32'h0000_0804, 3'd3, 16'h0031, 64'h0123_4567_89ab_cdef, 0},
    '{OP_RD,   32'h0000_0900, 3'd2, 16'h0032, 64'h0, 0},
    '{OP_BOTH, 32'h0000_0100, 3'd3, 16'h0041, 64'h0f0f_1e1e_2d2d_3c3c, 0},
    '{OP_RD,   32'h0000_0100, 3'd3, 16'h0043, 64'h0, 5},
    '{OP_WR,   32'h0000_0300, 3'd1, 16'h0051, 64'h5555_aaaa_1234_9876, 4},
    '{OP_RD,   32'h0000_0300, 3'd0, 16'h0052, 64'h0, 0},
    '{OP_RD,   32'h0000_0104, 3'd2, 16'h0053, 64'h0, 0}
  };

  logic                            ACLK, ARESETn;
  logic                            arvalid, arready, awvalid, awready, wvalid, wready;
  logic [`AXI2APB_ADDR_W-1:0]      araddr, awaddr, paddr;
  axi_size_t                       arsize, awsize;
  axi_id_t                         arid, awid, rid, bid;
  axi_data_u                       wdata, rdata;
  logic                            rvalid, rready, rlast, bvalid, bready;
  axi_resp_t                       rresp, bresp;
  logic                            psel, penable, pwrite, pready, pslverr;
  logic [`AXI2APB_APB_DATA_W-1:0]  pwdata, prdata;

  logic [`AXI2APB_APB_DATA_W-1:0]  slave_mem [1024];
  logic [`AXI2APB_APB_DATA_W-1:0]  ref_mem   [1024];  // Expected memory contents
  resp_t                           exp_q [$];
  int                              accepted;
  int                              answered;
  int                              total_resp;

  tb_clock_gen u_clk (.ACLK, .ARESETn);

  axi2apb_top DUT
  (
    .ACLK, .ARESETn,
    .arvalid_i (arvalid), .arready_o (arready), .araddr_i (araddr),
    .arsize_i  (arsize),  .arid_i    (arid),
    .awvalid_i (awvalid), .awready_o (awready), .awaddr_i (awaddr),
    .awsize_i  (awsize),  .awid_i    (awid),
    .wvalid_i  (wvalid),  .wready_o  (wready),  .wdata_i  (wdata),
    .rvalid_o  (rvalid),  .rready_i  (rready),  .rid_o    (rid),
    .rdata_o   (rdata),   .rresp_o   (rresp),   .rlast_o  (rlast),
    .bvalid_o  (bvalid),  .bready_i  (bready),  .bid_o    (bid),   .bresp_o (bresp),
    .psel_o    (psel),    .penable_o (penable), .pwrite_o (pwrite),
    .paddr_o   (paddr),   .pwdata_o  (pwdata),  .prdata_i (prdata),
    .pready_i  (pready),  .pslverr_i (pslverr)
  );

  // --------------------------------------------------
  // Helpers
  // --------------------------------------------------
  task automatic abort_run(string why);
    $display("%s", why);
    $display("Test failed");
    $fatal(1, "Run stopped on the first error");
  endtask

  task automatic mismatch(string what);
    abort_run($sformatf("MISMATCH at time %0t: %s", $time, what));
  endtask

  function automatic logic [31:0] fill_word(int idx);
    return 32'(idx) * 32'h9e37_79b1 + 32'h0bad_0000;  // Odd multiplier spreads every index bit
  endfunction

  function automatic logic is_err(logic [31:0] a);
    return a >= 32'h0000_0800;
  endfunction

  function automatic logic [31:0] ref_read(logic [31:0] a);
    return is_err(a) ? 32'h0 : ref_mem[a[11:2]];
  endfunction

  function automatic logic [102:0] resp_snapshot();
    return {rvalid, rlast, rid, rdata, rresp, bvalid, bid, bresp};
  endfunction

  // Expected result per the splitting rules, applied to the reference memory
  task automatic expect_op(logic wr, logic [31:0] addr, axi_size_t size, axi_id_t id,
                           logic [63:0] wd, int stall);
    resp_t       e;
    axi_data_u   wu;
    logic [31:0] a0;
    logic [31:0] a1;
    logic        two;
    logic        lane;
    two     = (size == axi_size_t'(`AXI2APB_SIZE_64));
    a0      = two ? {addr[31:3], 3'b000} : {addr[31:2], 2'b00};
    a1      = a0 + `AXI2APB_WORD_OFFSET;
    lane    = two ? 1'b0 : addr[2];
    wu.full = wd;
    e.is_write  = wr;
    e.id        = id;
    e.stall     = stall;
    e.data.full = '0;
    e.resp      = (is_err(a0) || (two && is_err(a1))) ? SLVERR : OKAY;
    if (wr)
    begin
      if (!is_err(a0))
        ref_mem[a0[11:2]] = wu.lanes[lane];
      if (two && !is_err(a1))
        ref_mem[a1[11:2]] = wu.lanes[1];
    end
    else
    begin
      e.data.lanes[lane] = ref_read(a0);
      if (two)
        e.data.lanes[1] = ref_read(a1);
    end
    exp_q.push_back(e);
  endtask

  // --------------------------------------------------
  // Request driver
  // --------------------------------------------------
  task automatic issue_all();
    logic    ar_pend;
    logic    aw_pend;
    logic    ar_fire;
    logic    aw_fire;
    axi_id_t wid;
    for (int i = 0; i < N_ROWS; i++)
    begin
      ar_pend = (rows[i].op != OP_WR);
      aw_pend = (rows[i].op != OP_RD);
      wid     = (rows[i].op == OP_BOTH) ? rows[i].id + 1'b1 : rows[i].id;
      if (ar_pend)  // Read goes first on a tie, so it sees the old memory
        expect_op(1'b0, rows[i].addr, rows[i].size, rows[i].id, '0, rows[i].stall);
      if (aw_pend)
        expect_op(1'b1, rows[i].addr, rows[i].size, wid, rows[i].wdata, rows[i].stall);
      if (ar_pend)
      begin
        arvalid = 1'b1;
        araddr  = rows[i].addr;
        arsize  = rows[i].size;
        arid    = rows[i].id;
      end
      if (aw_pend)
      begin
        awvalid    = 1'b1;
        wvalid     = 1'b1;
        awaddr     = rows[i].addr;
        awsize     = rows[i].size;
        awid       = wid;
        wdata.full = rows[i].wdata;
      end
      while (ar_pend || aw_pend)
      begin
        #4;  // Settled, one unit before the rising edge
        ar_fire = ar_pend && arready;
        aw_fire = aw_pend && awready && wready;
        assert (!(aw_fire && ar_pend))
        else
          abort_run("Write was accepted while a read request was still waiting");
        accepted += int'(ar_fire) + int'(aw_fire);
        @(negedge ACLK);
        if (ar_fire)
        begin
          arvalid = 1'b0;
          ar_pend = 1'b0;
        end
        if (aw_fire)
        begin
          awvalid = 1'b0;
          wvalid  = 1'b0;
          aw_pend = 1'b0;
        end
      end
    end
  endtask

  // --------------------------------------------------
  // Response checker
  // --------------------------------------------------
  task automatic check_all();
    resp_t        e;
    logic [102:0] snap;
    while (answered < total_resp)
    begin
      do
        @(negedge ACLK);
      while (!(rvalid || bvalid));
      assert (exp_q.size() > 0)
      else
        abort_run("A response arrived with no request outstanding");
      e = exp_q.pop_front();
      assert (bvalid == e.is_write && rvalid == !e.is_write)
      else
        mismatch($sformatf("response on the wrong channel, RVALID %b BVALID %b", rvalid, bvalid));
      if (e.is_write)
      begin
        assert (bid == e.id) else mismatch($sformatf("BID %h, expected %h", bid, e.id));
        assert (bresp == e.resp) else mismatch($sformatf("BRESP %s, expected %s",
                                                         bresp.name(), e.resp.name()));
      end
      else
      begin
        assert (rid == e.id) else mismatch($sformatf("RID %h, expected %h", rid, e.id));
        assert (rresp == e.resp) else mismatch($sformatf("RRESP %s, expected %s",
                                                         rresp.name(), e.resp.name()));
        assert (rdata.full == e.data.full)
        else
          mismatch($sformatf("RDATA %h, expected %h", rdata.full, e.data.full));
        assert (rlast) else mismatch("RLAST low with RVALID high");
      end
      snap = resp_snapshot();
      repeat (e.stall)
      begin
        @(negedge ACLK);
        assert (resp_snapshot() == snap)
        else
          mismatch("response changed while the ready was held low");
        assert (!psel)
        else
          abort_run("An APB access started while a response was still waiting");
        if (accepted - answered >= 2)  // One responding, one held
        begin
          assert (!arready && !awready && !wready)
          else
            abort_run("A request ready rose while the holding register was full");
        end
      end
      rready = !e.is_write;
      bready = e.is_write;
      @(negedge ACLK);
      rready = 1'b0;
      bready = 1'b0;
      answered++;
    end
  endtask

  // --------------------------------------------------
  // APB slave model
  // --------------------------------------------------
  initial
  begin
    int         wait_cnt;
    logic [9:0] idx;
    void'($urandom(32'hd83e));
    wait_cnt = 0;
    pready   = 1'b0;
    pslverr  = 1'b0;
    prdata   = '0;
    for (int i = 0; i < 1024; i++)
      slave_mem[i] = fill_word(i);
    forever
    begin
      @(negedge ACLK);
      pready  = 1'b0;
      pslverr = 1'b0;
      idx     = paddr[11:2];
      if (psel && !penable)
        wait_cnt = $urandom % 3;  // 0 to 2 wait cycles
      else if (psel && penable)
      begin
        if (wait_cnt > 0)
          wait_cnt--;
        else
        begin
          pready  = 1'b1;
          pslverr = is_err(paddr);
          prdata  = is_err(paddr) ? '0 : slave_mem[idx];
          if (pwrite && !is_err(paddr))
            slave_mem[idx] = pwdata;
        end
      end
    end
  end

  // Watchdog with a margin per table row
  initial
  begin
    #((N_ROWS * 40 + 50) * 10);
    abort_run("Timeout: the bridge stopped answering requests");
  end

  initial
  begin
    arvalid    = 1'b0;
    araddr     = '0;
    arsize     = '0;
    arid       = '0;
    awvalid    = 1'b0;
    awaddr     = '0;
    awsize     = '0;
    awid       = '0;
    wvalid     = 1'b0;
    wdata.full = '0;
    rready     = 1'b0;
    bready     = 1'b0;
    accepted   = 0;
    answered   = 0;
    total_resp = 0;
    for (int i = 0; i < N_ROWS; i++)
      total_resp += (rows[i].op == OP_BOTH) ? 2 : 1;
    for (int i = 0; i < 1024; i++)
      ref_mem[i] = fill_word(i);
    wait (ARESETn === 1'b0);
    @(posedge ACLK);
    @(negedge ACLK);  // Inside the reset window
    assert (!arready && !awready && !wready && !psel && !penable && !rvalid && !bvalid)
    else
      abort_run("Bridge outputs were active during reset");
    wait (ARESETn === 1'b1);
    @(negedge ACLK);
    assert (arready)
    else
      abort_run("ARREADY did not rise in the first cycle after reset");
    fork
      issue_all();
      check_all();
    join
    repeat (3) @(negedge ACLK);
    if (DUT.u_assert.fail_cnt == 0)
    begin
      $display("Test passed");
      $finish;
    end
    else
    begin
      abort_run("Bound protocol assertions reported errors");
    end
  end

endmodule

// ==== axi2apb_assert.sv ====
module axi2apb_assert
(
  input  logic                ACLK,
  input  logic                ARESETn,
  input  logic                psel_i,
  input  logic                penable_i,
  input  logic                pready_i,
  input  apb_pkg::apb_addr_t  paddr_i,
  input  logic                rvalid_i,
  input  logic                rready_i,
  input  logic                bvalid_i,
  input  logic                bready_i
);

  int fail_cnt = 0;  // Read by the testbench at the end of the run

  // --------------------------------------------------
  // APB phases
  // --------------------------------------------------
  enable_after_select: assert property (@(posedge ACLK) disable iff (!ARESETn)
    penable_i |-> $past(psel_i))
  else
  begin
    $error("PENABLE rose without PSEL in the previous cycle");
    fail_cnt++;
  end

  // Address holds from setup until the access completes
  paddr_stable: assert property (@(posedge ACLK) disable iff (!ARESETn)
    (psel_i && !(penable_i && pready_i)) |=> $stable(paddr_i))
  else
  begin
    $error("PADDR changed in the middle of an APB access");
    fail_cnt++;
  end

  // --------------------------------------------------
  // AXI response channels
  // --------------------------------------------------
  rvalid_hold: assert property (@(posedge ACLK) disable iff (!ARESETn)
    (rvalid_i && !rready_i) |=> rvalid_i)
  else
  begin
    $error("RVALID dropped before RREADY");
    fail_cnt++;
  end

  bvalid_hold: assert property (@(posedge ACLK) disable iff (!ARESETn)
    (bvalid_i && !bready_i) |=> bvalid_i)
  else
  begin
    $error("BVALID dropped before BREADY");
    fail_cnt++;
  end

endmodule

bind axi2apb_top axi2apb_assert u_assert
(
  .ACLK      (ACLK),
  .ARESETn   (ARESETn),
  .psel_i    (psel_o),
  .penable_i (penable_o),
  .pready_i  (pready_i),
  .paddr_i   (paddr_o),
  .rvalid_i  (rvalid_o),
  .rready_i  (rready_i),
  .bvalid_i  (bvalid_o),
  .bready_i  (bready_i)
);

// ==== tb_clock_gen.sv ====
module tb_clock_gen
(
  output logic ACLK,
  output logic ARESETn
);

  // 10 unit period, first rising edge at 5
  initial
  begin
    ACLK = 1'b0;
    forever
      #5 ACLK = ~ACLK;
  end

  initial
  begin
    ARESETn = 1'b0;
    repeat (3) @(posedge ACLK);
    @(negedge ACLK);  // Release away from the active edge
    ARESETn = 1'b1;
  end

endmodule

// ==== axi2apb_top.sv ====
module axi2apb_top
(
  input  logic                ACLK,
  input  logic                ARESETn,

  // AXI read address
  input  logic                arvalid_i,
  output logic                arready_o,
  input  apb_pkg::apb_addr_t  araddr_i,
  input  axi_pkg::axi_size_t  arsize_i,
  input  axi_pkg::axi_id_t    arid_i,

  // AXI write address and data
  input  logic                awvalid_i,
  output logic                awready_o,
  input  apb_pkg::apb_addr_t  awaddr_i,
  input  axi_pkg::axi_size_t  awsize_i,
  input  axi_pkg::axi_id_t    awid_i,
  input  logic                wvalid_i,
  output logic                wready_o,
  input  axi_pkg::axi_data_u  wdata_i,

  // AXI read data
  output logic                rvalid_o,
  input  logic                rready_i,
  output axi_pkg::axi_id_t    rid_o,
  output axi_pkg::axi_data_u  rdata_o,
  output axi_pkg::axi_resp_t  rresp_o,
  output logic                rlast_o,

  // AXI write response
  output logic                bvalid_o,
  input  logic                bready_i,
  output axi_pkg::axi_id_t    bid_o,
  output axi_pkg::axi_resp_t  bresp_o,

  // APB3 requester
  output logic                psel_o,
  output logic                penable_o,
  output logic                pwrite_o,
  output apb_pkg::apb_addr_t  paddr_o,
  output apb_pkg::apb_data_t  pwdata_o,
  input  apb_pkg::apb_data_t  prdata_i,
  input  logic                pready_i,
  input  logic                pslverr_i
);

  import axi_pkg::*;
  import apb_pkg::*;

  // --------------------------------------------------
  // Capture to sequencer
  // --------------------------------------------------
  logic      req_valid, req_write, req_take;
  apb_addr_t req_addr;
  axi_size_t req_size;
  axi_id_t   req_id;
  axi_data_u req_wdata;

  // Sequencer to response unit
  logic      done, done_write, done_err, resp_busy;
  axi_id_t   done_id;
  axi_data_u done_rdata;

  axi_req_capture u_capture
  (
    .ACLK, .ARESETn,
    .arvalid_i, .araddr_i, .arsize_i, .arid_i,
    .awvalid_i, .awaddr_i, .awsize_i, .awid_i, .wvalid_i, .wdata_i,
    .req_take_i  (req_take),
    .arready_o, .awready_o, .wready_o,
    .req_valid_o (req_valid), .req_write_o (req_write), .req_addr_o (req_addr),
    .req_size_o  (req_size),  .req_id_o    (req_id),    .req_wdata_o (req_wdata)
  );

  apb_sequencer u_sequencer
  (
    .ACLK, .ARESETn,
    .req_valid_i (req_valid), .req_write_i (req_write), .req_addr_i  (req_addr),
    .req_size_i  (req_size),  .req_id_i    (req_id),    .req_wdata_i (req_wdata),
    .resp_busy_i (resp_busy),
    .prdata_i, .pready_i, .pslverr_i,
    .req_take_o  (req_take),
    .psel_o, .penable_o, .pwrite_o, .paddr_o, .pwdata_o,
    .done_o      (done),    .done_write_o (done_write), .done_id_o  (done_id),
    .done_rdata_o (done_rdata), .done_err_o (done_err)
  );

  axi_resp_unit u_resp
  (
    .ACLK, .ARESETn,
    .done_i      (done),    .done_write_i (done_write), .done_id_i  (done_id),
    .done_rdata_i (done_rdata), .done_err_i (done_err),
    .rready_i, .bready_i,
    .rvalid_o, .rlast_o, .rid_o, .rdata_o, .rresp_o,
    .bvalid_o, .bid_o, .bresp_o,
    .resp_busy_o (resp_busy)
  );

endmodule

// ==== axi_resp_unit.sv ====
module axi_resp_unit
(
  input  logic                ACLK,
  input  logic                ARESETn,

  // Completed request from the sequencer
  input  logic                done_i,
  input  logic                done_write_i,
  input  axi_pkg::axi_id_t    done_id_i,
  input  axi_pkg::axi_data_u  done_rdata_i,
  input  logic                done_err_i,

  input  logic                rready_i,
  input  logic                bready_i,

  // Read data channel
  output logic                rvalid_o,
  output logic                rlast_o,
  output axi_pkg::axi_id_t    rid_o,
  output axi_pkg::axi_data_u  rdata_o,
  output axi_pkg::axi_resp_t  rresp_o,

  // Write response channel
  output logic                bvalid_o,
  output axi_pkg::axi_id_t    bid_o,
  output axi_pkg::axi_resp_t  bresp_o,

  output logic                resp_busy_o
);

  import axi_pkg::*;

  logic      valid_q;  // A response is waiting
  logic      write_q;  // Selects B over R
  axi_id_t   id_q;
  axi_data_u rdata_q;
  axi_resp_t resp_q;

  logic      accepted;

  assign accepted = (rvalid_o & rready_i) | (bvalid_o & bready_i);

  // --------------------------------------------------
  // Response slot
  // --------------------------------------------------
  always_ff @(posedge ACLK, negedge ARESETn)
  begin
    if (!ARESETn)
    begin
      valid_q <= 1'b0;
      write_q <= 1'b0;
    end
    else if (done_i)
    begin
      valid_q <= 1'b1;  // Slot is always empty here
      write_q <= done_write_i;
    end
    else if (accepted)
    begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge ACLK)
  begin
    if (done_i)
    begin
      id_q    <= done_id_i;
      rdata_q <= done_rdata_i;
      resp_q  <= done_err_i ? SLVERR : OKAY;
    end
  end

  // R channel
  assign rvalid_o = valid_q & ~write_q;
  assign rlast_o  = rvalid_o;  // Single-beat reads only
  assign rid_o    = id_q;
  assign rdata_o  = rdata_q;
  assign rresp_o  = resp_q;

  // B channel
  assign bvalid_o = valid_q & write_q;
  assign bid_o    = id_q;
  assign bresp_o  = resp_q;

  assign resp_busy_o = valid_q;

endmodule

// ==== apb_sequencer.sv ====
`include "axi2apb_consts.svh"

module apb_sequencer
(
  input  logic                ACLK,
  input  logic                ARESETn,

  // Request from the holding register
  input  logic                req_valid_i,
  input  logic                req_write_i,
  input  apb_pkg::apb_addr_t  req_addr_i,
  input  axi_pkg::axi_size_t  req_size_i,
  input  axi_pkg::axi_id_t    req_id_i,
  input  axi_pkg::axi_data_u  req_wdata_i,

  input  logic                resp_busy_i,

  // APB completer side
  input  apb_pkg::apb_data_t  prdata_i,
  input  logic                pready_i,
  input  logic                pslverr_i,

  output logic                req_take_o,

  output logic                psel_o,
  output logic                penable_o,
  output logic                pwrite_o,
  output apb_pkg::apb_addr_t  paddr_o,
  output apb_pkg::apb_data_t  pwdata_o,

  // Result towards the response unit
  output logic                done_o,
  output logic                done_write_o,
  output axi_pkg::axi_id_t    done_id_o,
  output axi_pkg::axi_data_u  done_rdata_o,
  output logic                done_err_o
);

  import axi_pkg::*;
  import apb_pkg::*;

  typedef enum logic [1:0]
  {
    ST_IDLE,
    ST_SETUP,
    ST_ACCESS,
    ST_FINISH
  } seq_state_e;

  seq_state_e state_q;
  logic       word_idx_q;  // Set while the second word of a 64-bit beat runs

  // Copy of the request being executed
  logic       write_q;
  apb_addr_t  addr_q;
  axi_size_t  size_q;
  axi_id_t    id_q;
  axi_data_u  wdata_q;
  axi_data_u  rdata_q;
  logic       err_q;

  logic       is_64;
  logic       lane_sel;
  logic       access_end;
  apb_addr_t  base_addr;

  // --------------------------------------------------
  // Address and lane decode
  // --------------------------------------------------
  always_comb
  begin
    is_64 = (size_q == axi_size_t'(`AXI2APB_SIZE_64));
    if (is_64)
    begin
      base_addr = {addr_q[`AXI2APB_ADDR_W-1:3], 3'b000};
      lane_sel  = word_idx_q;  // Low lane first, then high
    end
    else
    begin
      base_addr = {addr_q[`AXI2APB_ADDR_W-1:2], 2'b00};
      lane_sel  = addr_q[2];   // Narrow access picks its own lane
    end
  end

  assign access_end = (state_q == ST_ACCESS) & pready_i;
  assign req_take_o = (state_q == ST_IDLE) & req_valid_i & ~resp_busy_i;

  // --------------------------------------------------
  // FSM
  // --------------------------------------------------
  always_ff @(posedge ACLK, negedge ARESETn)
  begin
    if (!ARESETn)
    begin
      state_q    <= ST_IDLE;
      word_idx_q <= 1'b0;
    end
    else
    begin
      case (state_q)
        ST_IDLE:
        begin
          if (req_take_o)
          begin
            state_q    <= ST_SETUP;
            word_idx_q <= 1'b0;
          end
        end
        ST_SETUP:
          state_q <= ST_ACCESS;
        ST_ACCESS:
        begin
          if (pready_i)
          begin
            if (is_64 && !word_idx_q)
            begin
              state_q    <= ST_SETUP;  // Go again for the upper word
              word_idx_q <= 1'b1;
            end
            else
            begin
              state_q <= ST_FINISH;
            end
          end
        end
        default:
          state_q <= ST_IDLE;  // FINISH lasts one cycle
      endcase
    end
  end

  // Request copy, read data and error collection
  always_ff @(posedge ACLK)
  begin
    if (req_take_o)
    begin
      write_q <= req_write_i;
      addr_q  <= req_addr_i;
      size_q  <= req_size_i;
      id_q    <= req_id_i;
      wdata_q <= req_wdata_i;
      rdata_q <= '0;   // Unfilled lanes read as zero
      err_q   <= 1'b0;
    end
    else if (access_end)
    begin
      if (!write_q)
        rdata_q.lanes[lane_sel] <= prdata_i;
      err_q <= err_q | pslverr_i;
    end
  end

  // --------------------------------------------------
  // APB outputs
  // --------------------------------------------------
  assign psel_o    = (state_q == ST_SETUP) | (state_q == ST_ACCESS);
  assign penable_o = (state_q == ST_ACCESS);
  assign pwrite_o  = write_q;
  assign paddr_o   = base_addr + (word_idx_q ? apb_addr_t'(`AXI2APB_WORD_OFFSET) : '0);
  assign pwdata_o  = wdata_q.lanes[lane_sel];

  assign done_o       = (state_q == ST_FINISH);
  assign done_write_o = write_q;
  assign done_id_o    = id_q;
  assign done_rdata_o = rdata_q;
  assign done_err_o   = err_q;

endmodule

// ==== axi_req_capture.sv ====
module axi_req_capture
(
  input  logic                ACLK,
  input  logic                ARESETn,

  // Read address channel
  input  logic                arvalid_i,
  input  apb_pkg::apb_addr_t  araddr_i,
  input  axi_pkg::axi_size_t  arsize_i,
  input  axi_pkg::axi_id_t    arid_i,

  // Write address and data channels
  input  logic                awvalid_i,
  input  apb_pkg::apb_addr_t  awaddr_i,
  input  axi_pkg::axi_size_t  awsize_i,
  input  axi_pkg::axi_id_t    awid_i,
  input  logic                wvalid_i,
  input  axi_pkg::axi_data_u  wdata_i,

  input  logic                req_take_i,

  output logic                arready_o,
  output logic                awready_o,
  output logic                wready_o,

  output logic                req_valid_o,
  output logic                req_write_o,
  output apb_pkg::apb_addr_t  req_addr_o,
  output axi_pkg::axi_size_t  req_size_o,
  output axi_pkg::axi_id_t    req_id_o,
  output axi_pkg::axi_data_u  req_wdata_o
);

  import axi_pkg::*;
  import apb_pkg::*;

  logic      ready_en_q;  // Low until the first edge after reset
  logic      req_valid_q;
  logic      req_write_q;
  apb_addr_t req_addr_q;
  axi_size_t req_size_q;
  axi_id_t   req_id_q;
  axi_data_u req_wdata_q;

  logic      ar_fire;
  logic      aw_fire;

  // --------------------------------------------------
  // Acceptance with reads winning over writes
  // --------------------------------------------------
  assign arready_o = ready_en_q & ~req_valid_q;
  assign awready_o = arready_o & ~arvalid_i & awvalid_i & wvalid_i;  // AW and W together
  assign wready_o  = awready_o;

  assign ar_fire = arready_o & arvalid_i;
  assign aw_fire = awready_o;  // Already qualified by both valids

  always_ff @(posedge ACLK, negedge ARESETn)
  begin
    if (!ARESETn)
    begin
      ready_en_q  <= 1'b0;
      req_valid_q <= 1'b0;
    end
    else
    begin
      ready_en_q <= 1'b1;
      if (ar_fire || aw_fire)
        req_valid_q <= 1'b1;
      else if (req_take_i)
        req_valid_q <= 1'b0;  // Sequencer has copied the request
    end
  end

  // Holding register contents
  always_ff @(posedge ACLK)
  begin
    if (ar_fire)
    begin
      req_write_q <= 1'b0;
      req_addr_q  <= araddr_i;
      req_size_q  <= arsize_i;
      req_id_q    <= arid_i;
    end
    else if (aw_fire)
    begin
      req_write_q <= 1'b1;
      req_addr_q  <= awaddr_i;
      req_size_q  <= awsize_i;
      req_id_q    <= awid_i;
      req_wdata_q <= wdata_i;
    end
  end

  assign req_valid_o = req_valid_q;
  assign req_write_o = req_write_q;
  assign req_addr_o  = req_addr_q;
  assign req_size_o  = req_size_q;
  assign req_id_o    = req_id_q;
  assign req_wdata_o = req_wdata_q;

endmodule

// ==== apb_pkg.sv ====
`include "axi2apb_consts.svh"

package apb_pkg;

  // Byte address on PADDR
  typedef logic [`AXI2APB_ADDR_W-1:0]     apb_addr_t;

  // One APB3 data word, PWDATA and PRDATA
  typedef logic [`AXI2APB_APB_DATA_W-1:0] apb_data_t;

endpackage

// ==== axi_pkg.sv ====
`include "axi2apb_consts.svh"

package axi_pkg;

  // Response codes on R and B
  typedef enum logic [1:0]
  {
    OKAY   = 2'b00,
    EXOKAY = 2'b01,
    SLVERR = 2'b10,
    DECERR = 2'b11
  } axi_resp_t;

  typedef logic [2:0]               axi_size_t;  // Bytes = 2**size
  typedef logic [`AXI2APB_ID_W-1:0] axi_id_t;

  // One AXI data beat, seen whole or as two APB-sized lanes
  typedef union packed
  {
    logic [`AXI2APB_AXI_DATA_W-1:0]                                   full;
    logic [`AXI2APB_AXI_DATA_W/`AXI2APB_APB_DATA_W-1:0]
          [`AXI2APB_APB_DATA_W-1:0]                                   lanes; // Lane 0 low
  } axi_data_u;

endpackage

// ==== axi2apb_consts.svh ====
`ifndef AXI2APB_CONSTS_SVH
`define AXI2APB_CONSTS_SVH

// --------------------------------------------------
// Bus widths
// --------------------------------------------------
`define AXI2APB_ADDR_W      32
`define AXI2APB_ID_W        16
`define AXI2APB_AXI_DATA_W  64
`define AXI2APB_APB_DATA_W  32

// --------------------------------------------------
// Transfer splitting
// --------------------------------------------------
`define AXI2APB_WORD_OFFSET 4   // Byte step to the upper APB word
`define AXI2APB_SIZE_64     3   // AxSIZE for a full 64-bit beat

`endif
